/* verilog/mips_pkg.sv */
package mips_pkg;

	// ============================================================
	// Instruction fields
	// ============================================================

	localparam int OP_W    = 6;
	localparam int REG_W   = 5;
	localparam int SHAMT_W = 5;
	localparam int FUNCT_W = 6;
	localparam int IMM_W   = 16;
	localparam int TGT_W   = 26;

	typedef logic [31:0] word_t;
	typedef logic [REG_W-1:0] reg_addr_t;

	// r0 reads as zero and is never written
	localparam reg_addr_t ZERO_REG = 5'd0;
	// jal link target
	localparam reg_addr_t RA_REG   = 5'd31;

	// ============================================================
	// Decode results
	// ============================================================

	typedef enum logic [3:0] {
		KIND_NOP, KIND_ADDU, KIND_SUBU, KIND_ORI,
		KIND_LUI, KIND_LW, KIND_SW, KIND_BEQ,
		KIND_J, KIND_JAL, KIND_JR, KIND_MOVZ,
		KIND_UNKNOWN
	} instr_kind_t;

	// Class picks the datapath behaviour, kind refines it
	typedef enum logic [3:0] {
		CLS_NONE, CLS_CAL_R, CLS_CAL_I, CLS_LOAD, CLS_STORE,
		CLS_BRANCH, CLS_JUMP_I, CLS_JUMP_R, CLS_CMOV
	} instr_class_t;

	// ============================================================
	// Control word fields
	// ============================================================

	typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_OR, ALU_MOVZ} alu_op_t;

	typedef enum logic [1:0] {EXT_ZERO, EXT_SIGN, EXT_UPPER} ext_mode_t;

	typedef enum logic [1:0] {NPC_SEQ, NPC_BEQ, NPC_JUMP, NPC_REG} npc_mode_t;

	// Operand source, youngest ready producer wins
	typedef enum logic [2:0] {
		FWD_ORIG, FWD_M_ALU, FWD_M_LINK, FWD_W, FWD_E_LINK
	} fwd_src_t;

	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wb_sel_t;

endpackage

/* verilog/ctrl_if.sv */
`timescale 1ns/1ps

interface ctrl_if import mips_pkg::*; ();

	// Fetch and decode
	logic pc_en;
	logic d_en;
	logic e_bubble;
	npc_mode_t npc_mode;
	ext_mode_t ext_mode;

	// Execute, memory, writeback
	alu_op_t alu_op;
	logic alu_src;
	logic dm_we;
	logic rf_we;
	reg_addr_t rf_waddr;
	wb_sel_t wb_sel;

	// Forward selects per consumer stage
	fwd_src_t fwd_d1;
	fwd_src_t fwd_d2;
	fwd_src_t fwd_e1;
	fwd_src_t fwd_e2;
	fwd_src_t fwd_m;

	modport ctrl (
		output pc_en, d_en, e_bubble, npc_mode, ext_mode, alu_op, alu_src, dm_we,
		output rf_we, rf_waddr, wb_sel, fwd_d1, fwd_d2, fwd_e1, fwd_e2, fwd_m
	);

	modport dp (
		input pc_en, d_en, e_bubble, npc_mode, ext_mode, alu_op, alu_src, dm_we,
		input rf_we, rf_waddr, wb_sel, fwd_d1, fwd_d2, fwd_e1, fwd_e2, fwd_m
	);

endinterface

/* verilog/instr_decode.sv */
`timescale 1ns/1ps

module instr_decode import mips_pkg::*; (
	input word_t instr,
	output instr_kind_t kind,
	output instr_class_t iclass
);

	localparam logic [OP_W-1:0] OP_SPECIAL = 6'b000000;
	localparam logic [OP_W-1:0] OP_J       = 6'b000010;
	localparam logic [OP_W-1:0] OP_JAL     = 6'b000011;
	localparam logic [OP_W-1:0] OP_BEQ     = 6'b000100;
	localparam logic [OP_W-1:0] OP_ORI     = 6'b001101;
	localparam logic [OP_W-1:0] OP_LUI     = 6'b001111;
	localparam logic [OP_W-1:0] OP_LW      = 6'b100011;
	localparam logic [OP_W-1:0] OP_SW      = 6'b101011;

	localparam logic [FUNCT_W-1:0] FN_JR   = 6'b001000;
	localparam logic [FUNCT_W-1:0] FN_MOVZ = 6'b001010;
	localparam logic [FUNCT_W-1:0] FN_ADDU = 6'b100001;
	localparam logic [FUNCT_W-1:0] FN_SUBU = 6'b100011;

	logic [OP_W-1:0] op;
	logic [FUNCT_W-1:0] funct;
	logic [SHAMT_W-1:0] shamt;
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t rd;
	logic special;

	assign op      = instr[31:26];
	assign rs      = instr[25:21];
	assign rt      = instr[20:16];
	assign rd      = instr[15:11];
	assign shamt   = instr[10:6];
	assign funct   = instr[5:0];
	assign special = (op == OP_SPECIAL) && (shamt == '0);

	// First matching rule wins
	always_comb begin
		if (special && funct == FN_ADDU)
			kind = KIND_ADDU;
		else if (special && funct == FN_SUBU)
			kind = KIND_SUBU;
		else if (op == OP_LUI && rs == ZERO_REG)
			kind = KIND_LUI;
		else if (op == OP_ORI)
			kind = KIND_ORI;
		else if (op == OP_LW)
			kind = KIND_LW;
		else if (op == OP_SW)
			kind = KIND_SW;
		else if (op == OP_BEQ)
			kind = KIND_BEQ;
		else if (op == OP_J)
			kind = KIND_J;
		else if (op == OP_JAL)
			kind = KIND_JAL;
		else if (special && funct == FN_JR && rt == ZERO_REG && rd == ZERO_REG)
			kind = KIND_JR;
		else if (special && funct == FN_MOVZ)
			kind = KIND_MOVZ;
		else if (instr == '0)
			kind = KIND_NOP;
		else
			kind = KIND_UNKNOWN;
	end

	always_comb begin
		case (kind)
			KIND_ADDU, KIND_SUBU: iclass = CLS_CAL_R;
			KIND_ORI, KIND_LUI:   iclass = CLS_CAL_I;
			KIND_LW:              iclass = CLS_LOAD;
			KIND_SW:              iclass = CLS_STORE;
			KIND_BEQ:             iclass = CLS_BRANCH;
			KIND_J, KIND_JAL:     iclass = CLS_JUMP_I;
			KIND_JR:              iclass = CLS_JUMP_R;
			KIND_MOVZ:            iclass = CLS_CMOV;
			default:              iclass = CLS_NONE;
		endcase
	end

endmodule

/* verilog/hazard_ctrl.sv */
`timescale 1ns/1ps

module hazard_ctrl import mips_pkg::*; (
	input logic clk,
	input logic rst,
	input word_t d_instr,
	input word_t d_rt_val,
	ctrl_if.ctrl cw
);

	// Unused operand never causes a stall
	localparam logic [2:0] T_INF = 3'd7;

	word_t e_instr;
	word_t m_instr;
	word_t w_instr;

	instr_kind_t d_kind;
	instr_kind_t e_kind;
	instr_kind_t m_kind;
	instr_kind_t w_kind;
	instr_class_t d_cls;
	instr_class_t e_cls;
	instr_class_t m_cls;
	instr_class_t w_cls;

	reg_addr_t d_reg1;
	reg_addr_t d_reg2;
	reg_addr_t d_regw;
	reg_addr_t e_reg1;
	reg_addr_t e_reg2;
	reg_addr_t e_regw;
	reg_addr_t m_reg2;
	reg_addr_t m_regw;
	reg_addr_t w_regw;

	logic [2:0] t_use1;
	logic [2:0] t_use2;
	logic [2:0] t_new_e;
	logic [2:0] t_new_m;
	logic stall;

	instr_decode u_dec_d (.instr(d_instr), .kind(d_kind), .iclass(d_cls));
	instr_decode u_dec_e (.instr(e_instr), .kind(e_kind), .iclass(e_cls));
	instr_decode u_dec_m (.instr(m_instr), .kind(m_kind), .iclass(m_cls));
	instr_decode u_dec_w (.instr(w_instr), .kind(w_kind), .iclass(w_cls));

	// ============================================================
	// Stage tags
	// ============================================================

	always_comb begin
		d_reg1 = ZERO_REG;
		d_reg2 = ZERO_REG;
		d_regw = ZERO_REG;
		case (d_cls)
			CLS_CAL_R: begin
				d_reg1 = d_instr[25:21];
				d_reg2 = d_instr[20:16];
				d_regw = d_instr[15:11];
			end
			CLS_CAL_I, CLS_LOAD: begin
				d_reg1 = d_instr[25:21];
				d_regw = d_instr[20:16];
			end
			CLS_STORE, CLS_BRANCH: begin
				d_reg1 = d_instr[25:21];
				d_reg2 = d_instr[20:16];
			end
			CLS_JUMP_I: d_regw = (d_kind == KIND_JAL) ? RA_REG : ZERO_REG;
			CLS_JUMP_R: d_reg1 = d_instr[25:21];
			CLS_CMOV: begin
				d_reg1 = d_instr[25:21];
				d_reg2 = d_instr[20:16];
				// movz only writes when rt reads zero
				d_regw = (d_rt_val == '0) ? d_instr[15:11] : ZERO_REG;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			e_instr <= '0;
			m_instr <= '0;
			w_instr <= '0;
			e_reg1  <= ZERO_REG;
			e_reg2  <= ZERO_REG;
			e_regw  <= ZERO_REG;
			m_reg2  <= ZERO_REG;
			m_regw  <= ZERO_REG;
			w_regw  <= ZERO_REG;
		end else begin
			// Bubble turns the execute slot into a nop
			e_instr <= stall ? '0 : d_instr;
			e_reg1  <= stall ? ZERO_REG : d_reg1;
			e_reg2  <= stall ? ZERO_REG : d_reg2;
			e_regw  <= stall ? ZERO_REG : d_regw;
			m_instr <= e_instr;
			m_reg2  <= e_reg2;
			m_regw  <= e_regw;
			w_instr <= m_instr;
			w_regw  <= m_regw;
		end
	end

	// ============================================================
	// Stall
	// ============================================================

	always_comb begin
		case (d_cls)
			CLS_CAL_R, CLS_CAL_I, CLS_LOAD, CLS_STORE: t_use1 = 3'd1;
			CLS_BRANCH, CLS_JUMP_R, CLS_CMOV:          t_use1 = 3'd0;
			default:                                   t_use1 = T_INF;
		endcase
		case (d_cls)
			CLS_STORE:            t_use2 = 3'd2;
			CLS_CAL_R:            t_use2 = 3'd1;
			CLS_BRANCH, CLS_CMOV: t_use2 = 3'd0;
			default:              t_use2 = T_INF;
		endcase
		case (e_cls)
			CLS_LOAD:                      t_new_e = 3'd2;
			CLS_CAL_R, CLS_CAL_I, CLS_CMOV: t_new_e = 3'd1;
			default:                       t_new_e = 3'd0;
		endcase
		t_new_m = (m_cls == CLS_LOAD) ? 3'd1 : 3'd0;
	end

	function automatic logic hit(reg_addr_t r, logic [2:0] t_use);
		return (r != ZERO_REG) &&
			((r == e_regw && t_use < t_new_e) || (r == m_regw && t_use < t_new_m));
	endfunction

	always_comb begin
		stall = hit(d_reg1, t_use1) || hit(d_reg2, t_use2);
	end

	// ============================================================
	// Forwarding
	// ============================================================

	function automatic logic m_alu_ready();
		return m_cls == CLS_CAL_R || m_cls == CLS_CAL_I || m_cls == CLS_CMOV;
	endfunction

	function automatic fwd_src_t fwd_from_mw(reg_addr_t r);
		if (r == ZERO_REG)
			return FWD_ORIG;
		if (r == m_regw && m_cls == CLS_JUMP_I)
			return FWD_M_LINK;
		if (r == m_regw && m_alu_ready())
			return FWD_M_ALU;
		if (r == w_regw)
			return FWD_W;
		return FWD_ORIG;
	endfunction

	always_comb begin
		// jal link in execute is the only value ready there
		if (d_reg1 != ZERO_REG && d_reg1 == e_regw && e_cls == CLS_JUMP_I)
			cw.fwd_d1 = FWD_E_LINK;
		else
			cw.fwd_d1 = fwd_from_mw(d_reg1);
		if (d_reg2 != ZERO_REG && d_reg2 == e_regw && e_cls == CLS_JUMP_I)
			cw.fwd_d2 = FWD_E_LINK;
		else
			cw.fwd_d2 = fwd_from_mw(d_reg2);
		cw.fwd_e1 = fwd_from_mw(e_reg1);
		cw.fwd_e2 = fwd_from_mw(e_reg2);
		cw.fwd_m  = (m_reg2 != ZERO_REG && m_reg2 == w_regw) ? FWD_W : FWD_ORIG;
	end

	// ============================================================
	// Control word
	// ============================================================

	always_comb begin
		cw.pc_en    = !stall;
		cw.d_en     = !stall;
		cw.e_bubble = stall;

		case (d_cls)
			CLS_BRANCH: cw.npc_mode = NPC_BEQ;
			CLS_JUMP_I: cw.npc_mode = NPC_JUMP;
			CLS_JUMP_R: cw.npc_mode = NPC_REG;
			default:    cw.npc_mode = NPC_SEQ;
		endcase
		case (d_kind)
			KIND_ORI: cw.ext_mode = EXT_ZERO;
			KIND_LUI: cw.ext_mode = EXT_UPPER;
			default:  cw.ext_mode = EXT_SIGN;
		endcase

		case (e_kind)
			KIND_SUBU:          cw.alu_op = ALU_SUB;
			KIND_ORI, KIND_LUI: cw.alu_op = ALU_OR;
			KIND_MOVZ:          cw.alu_op = ALU_MOVZ;
			default:            cw.alu_op = ALU_ADD;
		endcase
		cw.alu_src = (e_cls == CLS_CAL_I || e_cls == CLS_LOAD || e_cls == CLS_STORE);

		cw.dm_we = (m_kind == KIND_SW);

		cw.rf_we = (w_cls == CLS_CAL_R || w_cls == CLS_CAL_I || w_cls == CLS_LOAD ||
			w_cls == CLS_JUMP_I || w_cls == CLS_CMOV);
		cw.rf_waddr = w_regw;
		case (w_kind)
			KIND_LW:  cw.wb_sel = WB_MEM;
			KIND_JAL: cw.wb_sel = WB_LINK;
			default:  cw.wb_sel = WB_ALU;
		endcase
	end

endmodule

/* verilog/fetch_pc.sv */
`timescale 1ns/1ps

module fetch_pc import mips_pkg::*; #(
	parameter word_t RESET_PC = '0
) (
	input logic clk,
	input logic rst,
	input logic pc_en,
	input npc_mode_t npc_mode,
	input logic equal,
	input logic [TGT_W-1:0] target,
	input logic [IMM_W-1:0] offset,
	input word_t rs_val,
	output word_t pc
);

	word_t seq_pc;
	word_t br_pc;
	word_t jmp_pc;
	word_t next_pc;

	// pc already points at the delay slot when the branch is in decode
	assign seq_pc = pc + 32'd4;
	assign br_pc  = pc + {{14{offset[IMM_W-1]}}, offset, 2'b00};
	assign jmp_pc = {pc[31:28], target, 2'b00};

	always_comb begin
		case (npc_mode)
			NPC_BEQ:  next_pc = equal ? br_pc : seq_pc;
			NPC_JUMP: next_pc = jmp_pc;
			NPC_REG:  next_pc = rs_val;
			default:  next_pc = seq_pc;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			pc <= RESET_PC;
		else if (pc_en)
			pc <= next_pc;
	end

endmodule

/* verilog/reg_file.sv */
`timescale 1ns/1ps

module reg_file import mips_pkg::*; (
	input logic clk,
	input logic rst,
	input reg_addr_t raddr1,
	input reg_addr_t raddr2,
	output word_t rdata1,
	output word_t rdata2,
	input logic we,
	input reg_addr_t waddr,
	input word_t wdata
);

	word_t regs [1:31];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (we && waddr != ZERO_REG) begin
			regs[waddr] <= wdata;
		end
	end

	// Same-cycle write shows through on the read ports
	assign rdata1 = (raddr1 == ZERO_REG) ? '0 :
		(we && waddr == raddr1) ? wdata : regs[raddr1];
	assign rdata2 = (raddr2 == ZERO_REG) ? '0 :
		(we && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

/* verilog/alu.sv */
`timescale 1ns/1ps

module alu import mips_pkg::*; (
	input alu_op_t op,
	input word_t a,
	input word_t b,
	output word_t y
);

	always_comb begin
		case (op)
			ALU_ADD:
				y = a + b;
			ALU_SUB:
				y = a - b;
			// lui arrives here as zero or upper immediate
			ALU_OR:
				y = a | b;
			// movz moves rs, the write itself is decided in decode
			ALU_MOVZ:
				y = a;
			default:
				y = a + b;
		endcase
	end

endmodule

/* verilog/mips_core.sv */
`timescale 1ns/1ps

module mips_core import mips_pkg::*; #(
	parameter word_t RESET_PC = '0
) (
	input logic clk,
	input logic rst,
	output word_t imem_addr,
	input word_t imem_data,
	output word_t dmem_addr,
	output word_t dmem_wdata,
	output logic dmem_we,
	input word_t dmem_rdata
);

	ctrl_if cw ();

	word_t pc;
	word_t d_instr;
	word_t d_pc;
	word_t rf_rd1;
	word_t rf_rd2;
	word_t d_rs_val;
	word_t d_rt_val;
	word_t d_imm;
	word_t d_link;
	logic d_equal;

	word_t e_rs;
	word_t e_rt;
	word_t e_imm;
	word_t e_link;
	word_t e_a;
	word_t e_rt_fwd;
	word_t e_b;
	word_t e_alu;

	word_t m_alu;
	word_t m_rt;
	word_t m_link;

	word_t w_alu;
	word_t w_mem;
	word_t w_link;
	word_t w_data;

	function automatic word_t fwd_mux(fwd_src_t sel, word_t orig, word_t e_lnk,
			word_t m_res, word_t m_lnk, word_t w_res);
		case (sel)
			FWD_E_LINK: return e_lnk;
			FWD_M_ALU:  return m_res;
			FWD_M_LINK: return m_lnk;
			FWD_W:      return w_res;
			default:    return orig;
		endcase
	endfunction

	hazard_ctrl u_ctrl (
		.clk(clk),
		.rst(rst),
		.d_instr(d_instr),
		.d_rt_val(d_rt_val),
		.cw(cw.ctrl)
	);

	// ============================================================
	// Fetch and decode
	// ============================================================

	fetch_pc #(.RESET_PC(RESET_PC)) u_pc (
		.clk(clk),
		.rst(rst),
		.pc_en(cw.pc_en),
		.npc_mode(cw.npc_mode),
		.equal(d_equal),
		.target(d_instr[TGT_W-1:0]),
		.offset(d_instr[IMM_W-1:0]),
		.rs_val(d_rs_val),
		.pc(pc)
	);

	assign imem_addr = pc;

	always_ff @(posedge clk) begin
		if (rst)
			d_instr <= '0;
		else if (cw.d_en)
			d_instr <= imem_data;
	end

	always_ff @(posedge clk) begin
		if (cw.d_en)
			d_pc <= pc;
	end

	reg_file u_rf (
		.clk(clk),
		.rst(rst),
		.raddr1(d_instr[25:21]),
		.raddr2(d_instr[20:16]),
		.rdata1(rf_rd1),
		.rdata2(rf_rd2),
		.we(cw.rf_we),
		.waddr(cw.rf_waddr),
		.wdata(w_data)
	);

	assign d_rs_val = fwd_mux(cw.fwd_d1, rf_rd1, e_link, m_alu, m_link, w_data);
	assign d_rt_val = fwd_mux(cw.fwd_d2, rf_rd2, e_link, m_alu, m_link, w_data);
	assign d_equal  = (d_rs_val == d_rt_val);
	// Return address skips the delay slot
	assign d_link   = d_pc + 32'd8;

	always_comb begin
		case (cw.ext_mode)
			EXT_ZERO:  d_imm = {16'b0, d_instr[IMM_W-1:0]};
			EXT_UPPER: d_imm = {d_instr[IMM_W-1:0], 16'b0};
			default:   d_imm = {{16{d_instr[IMM_W-1]}}, d_instr[IMM_W-1:0]};
		endcase
	end

	// ============================================================
	// Execute
	// ============================================================

	// Bubble slot carries no data, so the registers simply hold
	always_ff @(posedge clk) begin
		if (!cw.e_bubble) begin
			e_rs   <= d_rs_val;
			e_rt   <= d_rt_val;
			e_imm  <= d_imm;
			e_link <= d_link;
		end
	end

	assign e_a      = fwd_mux(cw.fwd_e1, e_rs, e_link, m_alu, m_link, w_data);
	assign e_rt_fwd = fwd_mux(cw.fwd_e2, e_rt, e_link, m_alu, m_link, w_data);
	assign e_b      = cw.alu_src ? e_imm : e_rt_fwd;

	alu u_alu (
		.op(cw.alu_op),
		.a(e_a),
		.b(e_b),
		.y(e_alu)
	);

	// ============================================================
	// Memory and writeback
	// ============================================================

	always_ff @(posedge clk) begin
		m_alu  <= e_alu;
		m_rt   <= e_rt_fwd;
		m_link <= e_link;
	end

	assign dmem_addr  = m_alu;
	assign dmem_wdata = fwd_mux(cw.fwd_m, m_rt, e_link, m_alu, m_link, w_data);
	assign dmem_we    = cw.dm_we;

	always_ff @(posedge clk) begin
		w_alu  <= m_alu;
		w_mem  <= dmem_rdata;
		w_link <= m_link;
	end

	always_comb begin
		case (cw.wb_sel)
			WB_MEM:  w_data = w_mem;
			WB_LINK: w_data = w_link;
			default: w_data = w_alu;
		endcase
	end

endmodule

/* bench/core_assert.sv */
`timescale 1ns/1ps

module core_assert import mips_pkg::*; (
	input logic clk,
	input logic rst,
	input logic stall,
	input word_t d_instr,
	input word_t e_instr,
	input logic dm_we
);

	// Count of failed assertions
	int assert_errors = 0;

	// First edge still sees unreset stage registers, so look one edge back
	a_no_stall_in_reset: assert property (@(posedge clk) rst && $past(rst) |-> !stall)
		else begin
			$error("stall raised while reset is active");
			assert_errors++;
		end

	// A stalled decode holds and leaves a nop behind in execute
	a_bubble_after_stall: assert property (@(posedge clk) disable iff (rst)
		stall |=> e_instr == '0 && $stable(d_instr))
		else begin
			$error("stall did not hold decode or put a bubble into execute");
			assert_errors++;
		end

	a_no_store_after_reset: assert property (@(posedge clk) $fell(rst) |-> !dm_we)
		else begin
			$error("store enable high in the first cycle after reset");
			assert_errors++;
		end

endmodule

bind hazard_ctrl core_assert u_assert (
	.clk(clk),
	.rst(rst),
	.stall(stall),
	.d_instr(d_instr),
	.e_instr(e_instr),
	.dm_we(cw.dm_we)
);

/* bench/core_tb.sv */
`timescale 1ns/1ps

module core_tb import mips_pkg::*; ();

	localparam word_t RESET_PC = 32'h0000_1000;
	localparam int ROM_WORDS = 512;
	localparam int RAM_WORDS = 256;
	localparam int CLK_PERIOD = 10;

	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_J = 6'h02;
	localparam logic [5:0] OP_JAL = 6'h03;
	localparam logic [5:0] OP_BEQ = 6'h04;
	localparam logic [5:0] OP_ORI = 6'h0d;
	localparam logic [5:0] OP_LUI = 6'h0f;
	localparam logic [5:0] OP_LW = 6'h23;
	localparam logic [5:0] OP_SW = 6'h2b;
	localparam logic [5:0] FN_JR = 6'h08;
	localparam logic [5:0] FN_MOVZ = 6'h0a;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;

	logic clk;
	logic rst;
	word_t imem_addr;
	word_t imem_data;
	word_t dmem_addr;
	word_t dmem_wdata;
	logic dmem_we;
	word_t dmem_rdata;

	word_t rom [0:ROM_WORDS-1];
	word_t ram [0:RAM_WORDS-1];
	word_t exp_addr [$];
	word_t exp_data [$];
	int prog_len;
	int exp_count;
	int seen;
	logic prog_ready;
	integer seed;

	mips_core #(.RESET_PC(RESET_PC)) uut (
		.clk(clk),
		.rst(rst),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_we(dmem_we),
		.dmem_rdata(dmem_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ============================================================
	// Reporting and compares
	// ============================================================

	task automatic stop_run(string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_addr(string name, word_t got, word_t exp);
		if (got !== exp)
			stop_run($sformatf("Error at %0t: %s got %h, expected %h", $time, name, got, exp));
	endtask

	task automatic check_data(string name, word_t got, word_t exp);
		if (got !== exp)
			stop_run($sformatf("Error at %0t: %s got %h, expected %h", $time, name, got, exp));
	endtask

	task automatic check_flag(string name, logic got, logic exp);
		if (got !== exp)
			stop_run($sformatf("Error at %0t: %s got %b, expected %b", $time, name, got, exp));
	endtask

	// ============================================================
	// Program generator
	// ============================================================

	function automatic word_t fill_word(int i);
		return 32'h9e37_79b9 * (i + 1);
	endfunction

	function automatic int draw(int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic logic [15:0] ram_off();
		return 16'(draw(RAM_WORDS) * 4);
	endfunction

	// Distinct registers 1..30 within one block
	function automatic reg_addr_t pick(int base, int k);
		return reg_addr_t'(1 + (base + k) % 30);
	endfunction

	function automatic word_t r_format(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
			logic [5:0] funct);
		return {OP_SPECIAL, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic word_t i_format(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
			logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t j_format(logic [5:0] op, int idx);
		word_t addr;
		addr = RESET_PC + word_t'(idx) * 4;
		return {op, addr[27:2]};
	endfunction

	task automatic emit(word_t w);
		rom[prog_len] = w;
		prog_len++;
	endtask

	// Dependent ALU chain forwarded from memory and writeback
	task automatic alu_block();
		int b;
		b = draw(30);
		emit(i_format(OP_ORI, ZERO_REG, pick(b, 0), 16'(draw(65536))));
		emit(i_format(OP_LUI, ZERO_REG, pick(b, 1), 16'(draw(65536))));
		emit(r_format(pick(b, 0), pick(b, 1), pick(b, 2), FN_ADDU));
		emit(r_format(pick(b, 2), pick(b, 0), pick(b, 3), FN_SUBU));
		emit(i_format(OP_ORI, pick(b, 3), pick(b, 4), 16'(draw(65536))));
		emit(i_format(OP_SW, ZERO_REG, pick(b, 4), ram_off()));
		emit(i_format(OP_SW, ZERO_REG, pick(b, 2), ram_off()));
	endtask

	// Load-use stall, then a store fed by the memory forward
	task automatic load_block();
		int b;
		b = draw(30);
		emit(i_format(OP_ORI, ZERO_REG, pick(b, 1), 16'(draw(65536))));
		emit(i_format(OP_LW, ZERO_REG, pick(b, 0), ram_off()));
		emit(r_format(pick(b, 0), pick(b, 1), pick(b, 2), FN_ADDU));
		emit(i_format(OP_SW, ZERO_REG, pick(b, 2), ram_off()));
		emit(i_format(OP_LW, ZERO_REG, pick(b, 3), ram_off()));
		emit(i_format(OP_SW, ZERO_REG, pick(b, 3), ram_off()));
	endtask

	task automatic branch_block();
		int b;
		int x;
		b = draw(30);
		emit(i_format(OP_ORI, ZERO_REG, pick(b, 0), 16'(draw(65536)) | 16'd1));
		// Not taken, p0 is never zero
		emit(i_format(OP_BEQ, pick(b, 0), ZERO_REG, 16'd2));
		emit(i_format(OP_SW, ZERO_REG, pick(b, 0), ram_off()));
		emit(i_format(OP_SW, ZERO_REG, pick(b, 0), ram_off()));
		// Taken over two stores
		emit(i_format(OP_BEQ, pick(b, 0), pick(b, 0), 16'd3));
		emit(r_format(pick(b, 0), pick(b, 0), pick(b, 1), FN_ADDU));
		emit(i_format(OP_SW, ZERO_REG, pick(b, 1), ram_off()));
		emit(i_format(OP_SW, ZERO_REG, pick(b, 0), ram_off()));
		x = prog_len;
		emit(j_format(OP_JAL, x + 4));
		emit(i_format(OP_SW, ZERO_REG, pick(b, 1), ram_off()));
		// Return lands here
		emit(j_format(OP_J, x + 8));
		emit(i_format(OP_ORI, ZERO_REG, pick(b, 2), 16'(draw(65536))));
		emit(i_format(OP_SW, ZERO_REG, RA_REG, ram_off()));
		emit(r_format(RA_REG, ZERO_REG, ZERO_REG, FN_JR));
		emit(i_format(OP_SW, ZERO_REG, pick(b, 0), ram_off()));
		emit(i_format(OP_SW, ZERO_REG, pick(b, 2), ram_off()));
		emit(i_format(OP_SW, ZERO_REG, pick(b, 2), ram_off()));
	endtask

	task automatic movz_block();
		int b;
		b = draw(30);
		emit(i_format(OP_ORI, ZERO_REG, pick(b, 0), 16'(draw(65536))));
		emit(i_format(OP_ORI, ZERO_REG, pick(b, 1), 16'(draw(65536))));
		emit(i_format(OP_ORI, ZERO_REG, pick(b, 2), 16'(draw(65536)) | 16'd1));
		emit(r_format(pick(b, 2), pick(b, 2), pick(b, 3), FN_SUBU));
		emit(r_format(pick(b, 0), pick(b, 3), pick(b, 4), FN_MOVZ));
		emit(r_format(pick(b, 0), pick(b, 2), pick(b, 1), FN_MOVZ));
		emit(i_format(OP_SW, ZERO_REG, pick(b, 4), ram_off()));
		emit(i_format(OP_SW, ZERO_REG, pick(b, 1), ram_off()));
	endtask

	task automatic build_program();
		int x;
		repeat (3) begin
			alu_block();
			load_block();
			branch_block();
			movz_block();
		end
		x = prog_len;
		emit(j_format(OP_J, x));
		emit(32'h0);
	endtask

	// ============================================================
	// Reference interpreter
	// ============================================================

	function automatic int ref_run();
		word_t regs [0:31];
		word_t mem [0:RAM_WORDS-1];
		word_t pc;
		word_t npc;
		word_t nxt;
		word_t ins;
		word_t a;
		word_t imm_s;
		word_t jaddr;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		int count;
		exp_addr.delete();
		exp_data.delete();
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		for (int i = 0; i < RAM_WORDS; i++)
			mem[i] = fill_word(i);
		pc = RESET_PC;
		npc = RESET_PC + 32'd4;
		count = 0;
		for (int steps = 0; steps < 100000; steps++) begin
			ins = rom[(pc - RESET_PC) >> 2];
			rs = ins[25:21];
			rt = ins[20:16];
			rd = ins[15:11];
			imm_s = {{16{ins[15]}}, ins[15:0]};
			jaddr = {npc[31:28], ins[25:0], 2'b00};
			// Jump to itself ends the program
			if (ins[31:26] == OP_J && jaddr == pc)
				break;
			nxt = npc + 32'd4;
			a = regs[rs] + imm_s;
			case (ins[31:26])
				OP_SPECIAL:
					case (ins[5:0])
						FN_ADDU: regs[rd] = regs[rs] + regs[rt];
						FN_SUBU: regs[rd] = regs[rs] - regs[rt];
						FN_JR:   nxt = regs[rs];
						FN_MOVZ: if (regs[rt] == '0) regs[rd] = regs[rs];
						default: ;
					endcase
				OP_ORI: regs[rt] = regs[rs] | {16'h0, ins[15:0]};
				OP_LUI: regs[rt] = {ins[15:0], 16'h0};
				OP_LW:  regs[rt] = mem[a[9:2]];
				OP_SW: begin
					mem[a[9:2]] = regs[rt];
					exp_addr.push_back(a);
					exp_data.push_back(regs[rt]);
					count++;
				end
				OP_BEQ: if (regs[rs] == regs[rt]) nxt = npc + (imm_s << 2);
				OP_J:   nxt = jaddr;
				OP_JAL: begin
					regs[31] = pc + 32'd8;
					nxt = jaddr;
				end
				default: ;
			endcase
			regs[0] = '0;
			pc = npc;
			npc = nxt;
		end
		return count;
	endfunction

	// ============================================================
	// Memories, monitor and watchdog
	// ============================================================

	always @(posedge clk) begin
		if (dmem_we === 1'b1)
			ram[dmem_addr[9:2]] = dmem_wdata;
		#1;
		imem_data = rom[(imem_addr - RESET_PC) >> 2];
		dmem_rdata = ram[dmem_addr[9:2]];
	end

	always @(negedge clk) begin
		if (!rst && dmem_we !== 1'b0) begin
			if (dmem_we !== 1'b1)
				stop_run("Store enable is unknown after reset");
			else if (seen >= exp_count)
				stop_run("A store appeared beyond the expected number of stores");
			else begin
				check_addr("dmem_addr", dmem_addr, exp_addr[seen]);
				check_data("dmem_wdata", dmem_wdata, exp_data[seen]);
				seen++;
			end
		end
	end

	// Eight cycles per instruction covers two stall cycles each
	initial begin
		wait (prog_ready === 1'b1);
		#((prog_len * 8 + 100) * CLK_PERIOD);
		stop_run($sformatf("Timeout with %0d of %0d stores seen", seen, exp_count));
	end

	initial begin
		rst = 1'b1;
		imem_data = '0;
		dmem_rdata = '0;
		seed = 32'he5633379;
		prog_len = 0;
		seen = 0;
		prog_ready = 1'b0;
		for (int i = 0; i < ROM_WORDS; i++)
			rom[i] = '0;
		for (int i = 0; i < RAM_WORDS; i++)
			ram[i] = fill_word(i);
		build_program();
		exp_count = ref_run();
		prog_ready = 1'b1;

		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		check_addr("imem_addr", imem_addr, RESET_PC);
		check_flag("dmem_we", dmem_we, 1'b0);

		wait (seen == exp_count);
		// Tail to catch stores from skipped paths
		repeat (20) @(posedge clk);
		if (uut.u_ctrl.u_assert.assert_errors == 0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			stop_run("Assertion failures were reported during the run");
		end
	end

endmodule

/* all.f */
verilog/mips_pkg.sv
verilog/ctrl_if.sv
verilog/instr_decode.sv
verilog/hazard_ctrl.sv
verilog/fetch_pc.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/mips_core.sv
bench/core_assert.sv
bench/core_tb.sv
